// ==== dv/ads1292_bfm.sv ====
// ads1292 driver model giving busy after writes, data ready pulses and a strobe log
`timescale 1ns/1ns

module ads1292_bfm (
	input logic i_CLK,
	input logic i_RST,
	input ecg_pkg::ads_ctrl_e i_ads_control, // strobes from the dut
	input logic i_frame_req, // one cycle request for a new frame
	input logic i_force_neg, // force channel 2 negative
	output logic o_ads_busy,
	output logic o_ads_data_ready,
	output ecg_pkg::ads_word_t o_ads_data_out,
	output int o_wreg_cnt, // strobe log
	output int o_rdatac_cnt,
	output int o_sdatac_cnt
);
	import ecg_pkg::*;

	int seed = 32'hac22; // fixed random seed
	int busy_cnt; // busy cycles left
	int dr_cnt; // data ready cycles left
	logic wreg_seen; // write strobe in the last cycle
	logic req_q; // request seen at the rising edge
	logic neg_q;
	ads_word_t frame_q = '0; // word on the data pins

	assign o_ads_busy = (busy_cnt != 0);
	assign o_ads_data_ready = (dr_cnt != 0);
	assign o_ads_data_out = frame_q;

	always @(posedge i_CLK) begin
		req_q <= i_frame_req;
		neg_q <= i_force_neg;
	end

	// ==================================================
	// model outputs move on the falling edge
	// ==================================================
	always @(negedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			{busy_cnt, dr_cnt, o_wreg_cnt, o_rdatac_cnt, o_sdatac_cnt} <= '0;
			wreg_seen <= 1'b0;
			frame_q <= '0;
		end else begin
			wreg_seen <= (i_ads_control == ADS_CB_WREG);
			if (wreg_seen)
				busy_cnt <= 3; // busy from the cycle after the strobe
			else if (busy_cnt != 0)
				busy_cnt <= busy_cnt - 1;
			case (i_ads_control)
				ADS_CB_WREG: o_wreg_cnt <= o_wreg_cnt + 1;
				ADS_CB_RDATAC: o_rdatac_cnt <= o_rdatac_cnt + 1;
				ADS_CB_SDATAC: o_sdatac_cnt <= o_sdatac_cnt + 1;
				default: ;
			endcase
			if (req_q && dr_cnt == 0) begin
				dr_cnt <= 2; // two cycle wide pulse
				frame_q <= {8'($random(seed)), 32'($random(seed)), 8'($random(seed)),
					neg_q | 1'($random(seed)), 23'($random(seed))}; // bit 23 is the ch2 sign
			end else if (dr_cnt != 0) begin
				dr_cnt <= dr_cnt - 1;
			end
		end
	end

endmodule

// ==== dv/tb_ecg_link.sv ====
// testbench for the ecg link driving host commands, an ads1292 model and a uart sink
`timescale 1ns/1ns

module tb_ecg_link;
	import ecg_pkg::*;

	logic clk = 1'b0;
	logic rst = 1'b1; // held for three cycles
	cmd_word_t rx_data = '0;
	logic rx_valid = 1'b0;
	logic tx_ready = 1'b1; // uart sink ready level
	logic frame_req = 1'b0;
	logic force_neg = 1'b0;
	logic run_req = 1'b0; // host asked for a run
	logic ovf_ok = 1'b0; // overflow expected from here on
	logic ready_prev; // ready as the framer saw it last cycle
	uart_frame_t tx_data;
	uart_frame_t exp_frame;
	logic tx_valid, chip_set, run_set, fifo_ovf, ads_busy, ads_dr;
	ads_ctrl_e ads_ctrl;
	logic [7:0] ads_addr, ads_din;
	ads_word_t ads_dout;
	int wreg_cnt, rdatac_cnt, sdatac_cnt; // strobe log from the model
	logic [3:0] wreg_idx; // next setup table entry
	sample_t exp_q [$]; // samples owed by the dut, oldest first

	ecg_link_top uut (
		.i_CLK(clk), .i_RST(rst), .i_uart_rx_data(rx_data), .i_uart_rx_valid(rx_valid),
		.i_uart_tx_ready(tx_ready), .o_uart_tx_data(tx_data), .o_uart_tx_valid(tx_valid),
		.o_ads_control(ads_ctrl), .o_ads_reg_addr(ads_addr), .o_ads_data_in(ads_din),
		.i_ads_busy(ads_busy), .i_ads_data_ready(ads_dr), .i_ads_data_out(ads_dout),
		.o_chip_set(chip_set), .o_run_set(run_set), .o_fifo_overflow(fifo_ovf)
	);

	ads1292_bfm bfm (
		.i_CLK(clk), .i_RST(rst), .i_ads_control(ads_ctrl), .i_frame_req(frame_req),
		.i_force_neg(force_neg), .o_ads_busy(ads_busy), .o_ads_data_ready(ads_dr),
		.o_ads_data_out(ads_dout), .o_wreg_cnt(wreg_cnt), .o_rdatac_cnt(rdatac_cnt),
		.o_sdatac_cnt(sdatac_cnt)
	);

	always #10 clk = ~clk; // 20 ns period
	always @(posedge clk) ready_prev <= tx_ready;

	task automatic report_error(input bit value_err, input string msg);
		if (value_err)
			$display("MISMATCH at %0t ns: %s", $time, msg);
		else
			$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	// ==================================================
	// checks
	// ==================================================
	assert property (@(posedge clk) disable iff (rst) !tx_valid || ready_prev)
		else report_error(0, "a frame was presented while the sink was not ready");
	assert property (@(posedge clk) disable iff (rst) !tx_valid || !$past(tx_valid))
		else report_error(0, "frames presented in two consecutive cycles");
	assert property (@(posedge clk) disable iff (rst) ads_ctrl != ADS_CB_RDATAC || run_req)
		else report_error(0, "rdatac strobe without a run command");
	assert property (@(posedge clk) disable iff (rst) !fifo_ovf || ovf_ok)
		else report_error(1, "overflow flag set with no push into a full fifo");

	always @(posedge clk) begin
		if (rst) begin
			wreg_idx <= '0;
		end else begin
			if (tx_valid) begin
				assert (exp_q.size() != 0) else report_error(0, "frame sent with no sample waiting");
				exp_frame = {FRAME_TAG_SAMPLE, exp_q.pop_front()}; // tag then sign extended ch2
				assert (tx_data == exp_frame)
					else report_error(1, $sformatf("frame %h, expected %h", tx_data, exp_frame));
			end
			if (ads_ctrl == ADS_CB_WREG) begin
				assert (wreg_idx < 4'(ADS_SETUP_COUNT)) else report_error(0, "too many setup writes");
				assert (ads_addr == ADS_SETUP_ADDR[wreg_idx] && ads_din == ADS_SETUP_DATA[wreg_idx])
					else report_error(1, $sformatf("setup write %0d addr %h data %h",
						wreg_idx, ads_addr, ads_din));
				wreg_idx <= wreg_idx + 1'b1;
			end
		end
	end

	// ==================================================
	// stimulus helpers
	// ==================================================
	function automatic logic probe(input int sel);
		case (sel)
			0: return chip_set;
			1: return run_set;
			2: return ads_dr;
			default: return exp_q.size() == 0; // model drained
		endcase
	endfunction

	task automatic wait_until(input int sel, input logic level, input int limit, input string what);
		int n;
		n = 0;
		while (probe(sel) !== level && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (probe(sel) !== level)
			report_error(0, $sformatf("timed out waiting for %s", what));
	endtask

	task automatic send_cmd(input logic [7:0] code);
		@(negedge clk);
		rx_data = {code, 8'h00}; // command byte in the upper half
		rx_valid = 1'b1;
		@(negedge clk);
		rx_valid = 1'b0;
		repeat (4) @(negedge clk); // decoder spacing
	endtask

	task automatic pulse_frame(input logic neg, input logic expected);
		@(negedge clk);
		frame_req = 1'b1;
		force_neg = neg;
		@(negedge clk);
		frame_req = 1'b0;
		wait_until(2, 1'b1, 10, "data ready from the model");
		if (expected)
			exp_q.push_back(sample_t'($signed(ads_dout[23:0])));
		wait_until(2, 1'b0, 10, "data ready to fall");
	endtask

	initial begin
		repeat (3) @(negedge clk);
		rst = 1'b0;
		assert (ads_ctrl == ADS_CB_IDLE && !tx_valid && !chip_set && !run_set && !fifo_ovf
			&& uut.u_fifo.o_empty) else report_error(1, "outputs not inactive after reset");
		wait_until(0, 1'b1, 300, "chip_set after setup");
		assert (wreg_cnt == ADS_SETUP_COUNT && wreg_idx == 4'(ADS_SETUP_COUNT) && rdatac_cnt == 0)
			else report_error(1, $sformatf("%0d setup writes seen", wreg_cnt));
		run_req = 1'b1;
		send_cmd(CMD_RUN);
		wait_until(1, 1'b1, 20, "run_set after the run command");
		send_cmd(8'h41); // unknown byte
		assert (run_set && rdatac_cnt == 1 && sdatac_cnt == 0)
			else report_error(1, "run state or strobe count wrong after run");
		for (int i = 0; i < 6; i++)
			pulse_frame(i == 2, 1'b1); // third word forced negative
		wait_until(3, 1'b1, 50, "streamed frames");
		tx_ready = 1'b0; // back-pressure fills the fifo without overflow
		for (int i = 0; i < 8; i++)
			pulse_frame(1'b0, 1'b1);
		repeat (4) @(negedge clk);
		tx_ready = 1'b1;
		wait_until(3, 1'b1, 60, "backlog of eight frames");
		tx_ready = 1'b0; // ten into eight slots
		ovf_ok = 1'b1;
		for (int i = 0; i < 10; i++)
			pulse_frame(1'b0, i < 8);
		repeat (4) @(negedge clk);
		assert (fifo_ovf) else report_error(1, "overflow flag low after pushes into a full fifo");
		tx_ready = 1'b1;
		wait_until(3, 1'b1, 60, "first eight frames after overflow");
		repeat (10) @(negedge clk);
		run_req = 1'b0;
		send_cmd(CMD_STOP);
		wait_until(1, 1'b0, 20, "run_set to fall after the stop command");
		assert (sdatac_cnt == 1 && rdatac_cnt == 1)
			else report_error(1, "strobe count wrong after stop");
		send_cmd(8'h41); // unknown byte leaves the chip stopped
		for (int i = 0; i < 3; i++)
			pulse_frame(1'b0, 1'b0);
		repeat (20) @(negedge clk); // any frame here trips the checker
		$display("NO ERRORS");
		$finish;
	end

endmodule

// ==== hw/ads_sequencer.sv ====
// ads1292 sequencer for power-up writes, rdatac/sdatac control and channel 2 sample capture
`timescale 1ns/1ns

module ads_sequencer (
	input logic i_CLK,
	input logic i_RST,
	input logic i_run_mode, // run level from the host decoder
	input logic i_ads_busy, // driver still working on the last strobe
	input logic i_ads_data_ready, // new rdatac frame available
	input ecg_pkg::ads_word_t i_ads_data_out, // rdatac frame
	output ecg_pkg::ads_ctrl_e o_ads_control, // one cycle strobes
	output logic [7:0] o_ads_reg_addr,
	output logic [7:0] o_ads_data_in,
	output logic o_chip_set, // setup table written
	output logic o_run_set, // chip in rdatac mode
	output logic o_push, // one cycle push into the sample fifo
	output ecg_pkg::sample_t o_sample
);
	import ecg_pkg::*;

	// ==================================================
	// control fsm
	// ==================================================
	typedef enum logic [2:0] {
		ST_SETUP, // issue next table write or finish setup
		ST_WREG, // write strobe on the pins
		ST_GAP, // busy not raised yet by the driver
		ST_WAIT, // wait for busy low
		ST_STANDBY, // chip ready and idle
		ST_RUN // streaming frames
	} state_e;

	state_e r_state;
	logic [ADS_SETUP_IDX_W-1:0] r_setup_cnt; // next table entry

	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			r_state <= ST_SETUP;
			r_setup_cnt <= '0;
			o_ads_control <= ADS_CB_IDLE;
			o_ads_reg_addr <= '0;
			o_ads_data_in <= '0;
			o_chip_set <= 1'b0;
			o_run_set <= 1'b0;
		end else begin
			o_ads_control <= ADS_CB_IDLE; // every strobe drops after one cycle
			case (r_state)
				ST_SETUP: begin
					if (r_setup_cnt == ADS_SETUP_IDX_W'(ADS_SETUP_COUNT)) begin
						o_chip_set <= 1'b1; // sticky until reset
						r_state <= ST_STANDBY;
					end else begin
						o_ads_control <= ADS_CB_WREG;
						o_ads_reg_addr <= ADS_SETUP_ADDR[r_setup_cnt]; // held after strobe
						o_ads_data_in <= ADS_SETUP_DATA[r_setup_cnt];
						r_setup_cnt <= r_setup_cnt + 1'b1;
						r_state <= ST_WREG;
					end
				end
				ST_WREG: begin
					r_state <= ST_GAP;
				end
				ST_GAP: begin
					r_state <= ST_WAIT; // busy ignored in this cycle
				end
				ST_WAIT: begin
					if (!i_ads_busy)
						r_state <= ST_SETUP;
				end
				ST_STANDBY: begin
					if (i_run_mode && o_chip_set) begin
						o_ads_control <= ADS_CB_RDATAC;
						o_run_set <= 1'b1; // rises with the rdatac strobe
						r_state <= ST_RUN;
					end
				end
				ST_RUN: begin
					if (!i_run_mode) begin
						o_ads_control <= ADS_CB_SDATAC;
						o_run_set <= 1'b0; // later frames are ignored
						r_state <= ST_STANDBY;
					end
				end
				default: begin
					r_state <= ST_SETUP;
				end
			endcase
		end
	end

	// ==================================================
	// frame capture
	// ==================================================
	logic r_dr_d; // data ready one cycle late
	logic r_cap_valid; // channel 2 held, push next cycle
	logic [23:0] r_ch2; // raw 24 bit two's complement sample
	logic w_take; // rising data ready while running

	assign w_take = i_ads_data_ready && !r_dr_d && o_run_set;

	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			r_dr_d <= 1'b0;
			r_cap_valid <= 1'b0;
			o_push <= 1'b0;
		end else begin
			r_dr_d <= i_ads_data_ready;
			r_cap_valid <= w_take;
			o_push <= r_cap_valid; // two cycles after the sampled edge
		end
	end

	always_ff @(posedge i_CLK) begin
		if (w_take)
			r_ch2 <= i_ads_data_out[23:0];
		if (r_cap_valid)
			o_sample <= {{8{r_ch2[23]}}, r_ch2}; // sign extend to 32 bits
	end

endmodule

// ==== hw/ecg_link_top.sv ====
// ecg link top tying host decoder, ads1292 sequencer, sample fifo and uart framer together
`timescale 1ns/1ns

module ecg_link_top (
	input logic i_CLK,
	input logic i_RST,
	// uart receive
	input ecg_pkg::cmd_word_t i_uart_rx_data,
	input logic i_uart_rx_valid,
	// uart transmit
	input logic i_uart_tx_ready,
	output ecg_pkg::uart_frame_t o_uart_tx_data,
	output logic o_uart_tx_valid,
	// ads1292 driver
	output ecg_pkg::ads_ctrl_e o_ads_control,
	output logic [7:0] o_ads_reg_addr,
	output logic [7:0] o_ads_data_in,
	input logic i_ads_busy,
	input logic i_ads_data_ready,
	input ecg_pkg::ads_word_t i_ads_data_out,
	// status
	output logic o_chip_set,
	output logic o_run_set,
	output logic o_fifo_overflow
);
	import ecg_pkg::*;

	logic w_run_mode; // decoder to sequencer
	logic w_push; // sequencer to fifo
	sample_t w_sample;
	logic w_pop; // framer to fifo
	logic w_empty;
	sample_t w_head;

	host_cmd_decoder u_decoder (
		.i_CLK(i_CLK), .i_RST(i_RST),
		.i_uart_rx_data(i_uart_rx_data), .i_uart_rx_valid(i_uart_rx_valid),
		.o_run_mode(w_run_mode)
	);

	ads_sequencer u_sequencer (
		.i_CLK(i_CLK), .i_RST(i_RST), .i_run_mode(w_run_mode),
		.i_ads_busy(i_ads_busy), .i_ads_data_ready(i_ads_data_ready),
		.i_ads_data_out(i_ads_data_out), .o_ads_control(o_ads_control),
		.o_ads_reg_addr(o_ads_reg_addr), .o_ads_data_in(o_ads_data_in),
		.o_chip_set(o_chip_set), .o_run_set(o_run_set),
		.o_push(w_push), .o_sample(w_sample)
	);

	// full stays inside the fifo so capture runs regardless
	sample_fifo u_fifo (
		.i_CLK(i_CLK), .i_RST(i_RST), .i_push(w_push), .i_sample(w_sample),
		.i_pop(w_pop), .o_full(), .o_empty(w_empty), .o_head(w_head),
		.o_overflow(o_fifo_overflow)
	);

	uart_framer u_framer (
		.i_CLK(i_CLK), .i_RST(i_RST), .i_uart_tx_ready(i_uart_tx_ready),
		.i_empty(w_empty), .i_head(w_head), .o_pop(w_pop),
		.o_uart_tx_data(o_uart_tx_data), .o_uart_tx_valid(o_uart_tx_valid)
	);

endmodule

// ==== hw/ecg_pkg.sv ====
// ecg link shared definitions for host commands, ads1292 control codes, setup table and word types
package ecg_pkg;

	// ==================================================
	// host side codes
	// ==================================================
	localparam logic [7:0] CMD_RUN = 8'h52; // 'R' starts acquisition
	localparam logic [7:0] CMD_STOP = 8'h53; // 'S' stops acquisition
	localparam logic [7:0] FRAME_TAG_SAMPLE = 8'h41; // 'A' leads every sample frame

	// ==================================================
	// ads1292 driver control codes
	// ==================================================
	typedef enum logic [2:0] {
		ADS_CB_IDLE = 3'd0, // nothing requested
		ADS_CB_WREG = 3'd2, // single register write
		ADS_CB_RDATAC = 3'd4, // enter read data continuous
		ADS_CB_SDATAC = 3'd5 // leave read data continuous
	} ads_ctrl_e;

	// power-up register table, written in index order
	localparam int ADS_SETUP_COUNT = 11;
	localparam int ADS_SETUP_IDX_W = $clog2(ADS_SETUP_COUNT + 1); // counts one past the end

	localparam logic [7:0] ADS_SETUP_ADDR [ADS_SETUP_COUNT] = '{
		8'h01, // config1
		8'h02, // config2
		8'h03, // loff
		8'h04, // ch1set
		8'h05, // ch2set
		8'h06, // rld_sens
		8'h07, // loff_sens
		8'h08, // loff_stat
		8'h09, // resp1
		8'h0A, // resp2
		8'h0B // gpio
	};

	localparam logic [7:0] ADS_SETUP_DATA [ADS_SETUP_COUNT] = '{
		8'h02, 8'hA0, 8'h10, 8'h81, 8'h00, 8'h63,
		8'h0F, 8'h00, 8'h02, 8'h03, 8'h00
	};

	// ==================================================
	// sample buffer
	// ==================================================
	localparam int FIFO_DEPTH = 8; // power of two so pointers wrap by themselves
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

	// ==================================================
	// word types
	// ==================================================
	typedef logic signed [31:0] sample_t; // ecg sample after sign extension
	typedef logic [71:0] ads_word_t; // rdatac frame, channel 2 sits in bits 23:0
	typedef logic [39:0] uart_frame_t; // tag byte then sample
	typedef logic [15:0] cmd_word_t; // command byte in the upper half

endpackage

// ==== hw/host_cmd_decoder.sv ====
// host command decoder turning received uart words into the acquisition run level
`timescale 1ns/1ns

module host_cmd_decoder (
	input logic i_CLK,
	input logic i_RST,
	input ecg_pkg::cmd_word_t i_uart_rx_data, // word from uart receiver
	input logic i_uart_rx_valid, // one cycle pulse per word
	output logic o_run_mode // acquisition requested
);
	import ecg_pkg::*;

	// ==================================================
	// receive stage
	// ==================================================
	cmd_word_t r_rx_word; // last word taken from the receiver
	logic r_rx_pend; // word waiting for decode
	logic [7:0] w_cmd; // command byte of the held word

	assign w_cmd = r_rx_word[15:8]; // low byte carries no meaning here

	always_ff @(posedge i_CLK) begin
		if (i_uart_rx_valid)
			r_rx_word <= i_uart_rx_data;
	end

	// ==================================================
	// decode stage
	// ==================================================
	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			r_rx_pend <= 1'b0;
			o_run_mode <= 1'b0; // idle until the host asks
		end else begin
			r_rx_pend <= i_uart_rx_valid; // decode one cycle after capture
			if (r_rx_pend) begin
				if (w_cmd == CMD_RUN)
					o_run_mode <= 1'b1;
				else if (w_cmd == CMD_STOP)
					o_run_mode <= 1'b0;
				// any other byte keeps the level
			end
		end
	end

endmodule

// ==== hw/sample_fifo.sv ====
// sample fifo between capture and uart framer with full/empty and sticky overflow
`timescale 1ns/1ns

module sample_fifo (
	input logic i_CLK,
	input logic i_RST,
	input logic i_push, // one cycle write request
	input ecg_pkg::sample_t i_sample,
	input logic i_pop, // one cycle read request, head taken same cycle
	output logic o_full,
	output logic o_empty,
	output ecg_pkg::sample_t o_head, // oldest sample
	output logic o_overflow // a push was dropped since reset
);
	import ecg_pkg::*;

	sample_t r_mem [FIFO_DEPTH]; // circular storage
	logic [FIFO_PTR_W-1:0] r_wr_ptr; // next free slot
	logic [FIFO_PTR_W-1:0] r_rd_ptr; // head slot
	logic [FIFO_PTR_W:0] r_count; // entries held
	logic w_do_push; // push accepted
	logic w_do_pop; // pop accepted

	assign o_full = (r_count == (FIFO_PTR_W + 1)'(FIFO_DEPTH));
	assign o_empty = (r_count == '0);
	assign o_head = r_mem[r_rd_ptr];
	assign w_do_push = i_push && !o_full; // drop when full
	assign w_do_pop = i_pop && !o_empty;

	// ==================================================
	// pointers, count and overflow flag
	// ==================================================
	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			r_wr_ptr <= '0;
			r_rd_ptr <= '0;
			r_count <= '0;
			o_overflow <= 1'b0;
		end else begin
			if (w_do_push)
				r_wr_ptr <= r_wr_ptr + 1'b1; // wraps at depth
			if (w_do_pop)
				r_rd_ptr <= r_rd_ptr + 1'b1;
			case ({w_do_push, w_do_pop})
				2'b10: r_count <= r_count + 1'b1;
				2'b01: r_count <= r_count - 1'b1;
				default: r_count <= r_count; // none or both
			endcase
			if (i_push && o_full)
				o_overflow <= 1'b1; // held until reset
		end
	end

	always_ff @(posedge i_CLK) begin
		if (w_do_push)
			r_mem[r_wr_ptr] <= i_sample;
	end

endmodule

// ==== hw/uart_framer.sv ====
// uart framer popping samples and presenting tagged 40 bit frames to the transmitter
`timescale 1ns/1ns

module uart_framer (
	input logic i_CLK,
	input logic i_RST,
	input logic i_uart_tx_ready, // transmitter can take a frame
	input logic i_empty, // fifo has nothing
	input ecg_pkg::sample_t i_head, // fifo head sample
	output logic o_pop, // one cycle pop, head taken now
	output ecg_pkg::uart_frame_t o_uart_tx_data,
	output logic o_uart_tx_valid // one cycle per frame
);
	import ecg_pkg::*;

	// ==================================================
	// pop decision
	// ==================================================
	// skip the cycle a frame is on the bus so frames come at most every other cycle
	assign o_pop = i_uart_tx_ready && !i_empty && !o_uart_tx_valid;

	// ==================================================
	// frame register
	// ==================================================
	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST)
			o_uart_tx_valid <= 1'b0;
		else
			o_uart_tx_valid <= o_pop; // frame shows the cycle after pop
	end

	always_ff @(posedge i_CLK) begin
		if (o_pop)
			o_uart_tx_data <= {FRAME_TAG_SAMPLE, i_head}; // tag then sample
	end

endmodule

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ns -f sources.f --top-module tb_ecg_link \
	-o tb_ecg_link && ./obj_dir/tb_ecg_link | grep "NO ERRORS" \
	|| { echo "simulation failed"; exit 1; }

// ==== sources.f ====
hw/ecg_pkg.sv
hw/host_cmd_decoder.sv
hw/ads_sequencer.sv
hw/sample_fifo.sv
hw/uart_framer.sv
hw/ecg_link_top.sv
dv/ads1292_bfm.sv
dv/tb_ecg_link.sv
